// ==== design/a2_audio_mix.sv ====
/*
 * Audio mixer
 * Apple speaker toggle plus registered sum of speaker and card levels
 */

module a2_audio_mix (
    input  logic                                   clk_logic_w,
    input  logic                                   arst,
    input  logic                                   rst_i,
    input  a2_card_pkg::a2_addr_u                  addr_i,
    input  logic                                   access_stb_i,
    input  logic                                   sw_speaker_n_i,
    input  logic [a2_card_pkg::NUM_CARDS-1:0][7:0] level_i,
    output logic [a2_card_pkg::AUDIO_W-1:0]        audio_o
);

    localparam int AW = a2_card_pkg::AUDIO_W;

    logic          speaker_r;
    logic          spk_hit_w;
    logic [AW-1:0] sum_w;
    logic [AW-1:0] audio_r;

    // Any access to C030 flips the cone, read or write
    assign spk_hit_w = access_stb_i && !sw_speaker_n_i &&
                       (addr_i.raw == a2_card_pkg::SPEAKER_ADDR);

    always_comb begin
        sum_w = AW'({8{speaker_r}});                // Speaker is 0 or 255
        for (int i = 0; i < a2_card_pkg::NUM_CARDS; i++) begin
            sum_w = sum_w + AW'(level_i[i]);
        end
    end

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            speaker_r <= 1'b0;
            audio_r   <= '0;
        end else if (rst_i) begin
            speaker_r <= 1'b0;
            audio_r   <= '0;
        end else begin
            if (spk_hit_w) begin
                speaker_r <= ~speaker_r;
            end
            audio_r <= sum_w;
        end
    end

    assign audio_o = audio_r;

endmodule

// ==== design/a2_bus_arbiter.sv ====
/*
 * Apple data bus and IRQ arbiter
 * Lowest-indexed reading card owns the bus, interrupts are wire-ORed
 */

module a2_bus_arbiter (
    input  logic [a2_card_pkg::NUM_CARDS-1:0]      rd_en_i,
    input  logic [a2_card_pkg::NUM_CARDS-1:0][7:0] rd_data_i,
    input  logic [a2_card_pkg::NUM_CARDS-1:0]      irq_i,
    output logic [7:0]                             a2_d_o,
    output logic                                   a2_d_oe_o,
    output logic                                   a2_irq_n_o
);

    logic [7:0] bus_data_w;

    // Walk down from the last card so index 0 wins
    always_comb begin
        bus_data_w = '0;
        for (int i = a2_card_pkg::NUM_CARDS - 1; i >= 0; i--) begin
            if (rd_en_i[i]) begin
                bus_data_w = rd_data_i[i];
            end
        end
    end

    assign a2_d_o     = bus_data_w;
    assign a2_d_oe_o  = |rd_en_i;
    assign a2_irq_n_o = ~|irq_i;  // Active low, any card pulls it

endmodule

// ==== design/a2_bus_sync.sv ====
/*
 * Apple II bus sampler
 * Synchronizes phi1, turns its edges into strobes, captures address and data
 */

module a2_bus_sync (
    input  logic                  clk_logic_w,
    input  logic                  arst,
    input  logic                  rst_i,
    input  logic                  a2_phi1_i,
    input  logic [15:0]           a2_addr_i,
    input  logic                  a2_rw_n_i,
    input  logic [7:0]            a2_d_i,
    output a2_card_pkg::a2_addr_u addr_o,
    output logic                  rw_n_o,
    output logic [7:0]            wr_data_o,
    output logic                  access_stb_o,
    output logic                  end_stb_o,
    output logic                  wr_stb_o
);

    logic [2:0] phi1_sync_r;   // [1:0] synchronizer, [2] previous value
    logic       phi1_fall_w;
    logic       phi1_rise_w;

    a2_card_pkg::a2_addr_u addr_r;
    logic                  rw_n_r;
    logic [7:0]            wr_data_r;
    logic                  access_stb_r;
    logic                  end_stb_r;
    logic                  wr_stb_r;

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            phi1_sync_r <= '0;
        end else begin
            phi1_sync_r <= {phi1_sync_r[1:0], a2_phi1_i};
        end
    end

    assign phi1_fall_w = phi1_sync_r[2] & ~phi1_sync_r[1]; // phi0 starts
    assign phi1_rise_w = ~phi1_sync_r[2] & phi1_sync_r[1]; // phi0 ends

    // ======================================================================
    // Strobes and capture
    // ======================================================================

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            addr_r       <= '0;
            rw_n_r       <= 1'b1;
            wr_data_r    <= '0;
            access_stb_r <= 1'b0;
            end_stb_r    <= 1'b0;
            wr_stb_r     <= 1'b0;
        end else if (rst_i) begin
            access_stb_r <= 1'b0;
            end_stb_r    <= 1'b0;
            wr_stb_r     <= 1'b0;
        end else begin
            access_stb_r <= phi1_fall_w;
            end_stb_r    <= phi1_rise_w;
            wr_stb_r     <= phi1_rise_w & ~rw_n_r;
            if (phi1_fall_w) begin
                addr_r <= a2_addr_i;
                rw_n_r <= a2_rw_n_i;
            end
            // CPU data is only valid late in phi0
            if (phi1_rise_w && !rw_n_r) begin
                wr_data_r <= a2_d_i;
            end
        end
    end

    assign addr_o       = addr_r;
    assign rw_n_o       = rw_n_r;
    assign wr_data_o    = wr_data_r;
    assign access_stb_o = access_stb_r;
    assign end_stb_o    = end_stb_r;
    assign wr_stb_o     = wr_stb_r;

endmodule

// ==== design/a2_card_pkg.sv ====
/*
 * Apple II slot-card shared definitions
 * Address word views, bus constants and card register indices
 */

package a2_card_pkg;

    // ======================================================================
    // Apple address word
    // ======================================================================

    // I/O page split of an address: C0 page, device nibble, register nibble
    typedef struct packed {
        logic [7:0] page;
        logic [3:0] dev;
        logic [3:0] reg_sel;
    } a2_io_addr_t;

    // Raw for exact soft-switch matches, io for slot decode
    typedef union packed {
        logic [15:0] raw;
        a2_io_addr_t io;
    } a2_addr_u;

    // ======================================================================
    // Bus constants
    // ======================================================================

    localparam logic [7:0]  IO_PAGE       = 8'hC0;
    localparam logic [3:0]  DEV_SLOT_BASE = 4'd8;     // Slot n decodes at C0(8+n)x
    localparam logic [15:0] SPEAKER_ADDR  = 16'hC030; // Speaker toggle soft switch

    // Card register indices
    localparam logic [3:0] REG_AUDIO = 4'd14;         // Audio level byte
    localparam logic [3:0] REG_IRQ   = 4'd15;         // Bit 0 requests IRQ

    // Mixed audio holds three 8-bit sources
    localparam int AUDIO_W   = 10;
    localparam int NUM_CARDS = 2;

endpackage

// ==== design/a2_card_top.sv ====
/*
 * Apple II peripheral card core
 * Bus sampling, two slot cards, bus arbitration, audio mixing and LEDs
 */

module a2_card_top #(
    parameter int RESET_CYCLES     = 100,
    parameter int HEARTBEAT_CYCLES = 10_000_000,
    parameter int ACT_LED_BIT      = 10,
    parameter int SLOT_0           = 3,
    parameter int SLOT_1           = 4
) (
    input  logic                              clk_logic_w,
    input  logic                              arst,

    // Apple II bus
    input  logic                              a2_phi1_i,
    input  logic [15:0]                       a2_addr_i,
    input  logic                              a2_rw_n_i,
    input  logic [7:0]                        a2_d_i,
    input  logic                              a2_reset_n_i,

    input  logic                              sw_speaker_n_i, // DIP switch, 0 = speaker on

    output logic [7:0]                        a2_d_o,
    output logic                              a2_d_oe_o,
    output logic                              a2_irq_n_o,
    output logic [a2_card_pkg::AUDIO_W-1:0]   audio_o,
    output logic [1:0]                        led_o
);

    logic dev_rst_w;
    logic sys_rst_w;

    // Sampled bus
    a2_card_pkg::a2_addr_u addr_w;
    logic                  rw_n_w;
    logic [7:0]            wr_data_w;
    logic                  access_stb_w;
    logic                  end_stb_w;
    logic                  wr_stb_w;

    // Per-card outputs, index 0 has bus priority
    logic [a2_card_pkg::NUM_CARDS-1:0]       rd_en_w;
    logic [a2_card_pkg::NUM_CARDS-1:0][7:0]  rd_data_w;
    logic [a2_card_pkg::NUM_CARDS-1:0]       irq_w;
    logic [a2_card_pkg::NUM_CARDS-1:0][7:0]  level_w;

    a2_reset_gen #(
        .RESET_CYCLES(RESET_CYCLES)
    ) u_reset_gen (
        .clk_logic_w (clk_logic_w),
        .arst        (arst),
        .a2_reset_n_i(a2_reset_n_i),
        .dev_rst_o   (dev_rst_w),
        .sys_rst_o   (sys_rst_w)
    );

    a2_bus_sync u_bus_sync (
        .clk_logic_w (clk_logic_w),
        .arst        (arst),
        .rst_i       (sys_rst_w),
        .a2_phi1_i   (a2_phi1_i),
        .a2_addr_i   (a2_addr_i),
        .a2_rw_n_i   (a2_rw_n_i),
        .a2_d_i      (a2_d_i),
        .addr_o      (addr_w),
        .rw_n_o      (rw_n_w),
        .wr_data_o   (wr_data_w),
        .access_stb_o(access_stb_w),
        .end_stb_o   (end_stb_w),
        .wr_stb_o    (wr_stb_w)
    );

    // ======================================================================
    // Slot cards
    // ======================================================================

    a2_io_card #(
        .SLOT(SLOT_0)
    ) u_card_0 (
        .clk_logic_w (clk_logic_w),
        .arst        (arst),
        .rst_i       (sys_rst_w),
        .addr_i      (addr_w),
        .rw_n_i      (rw_n_w),
        .wr_data_i   (wr_data_w),
        .access_stb_i(access_stb_w),
        .end_stb_i   (end_stb_w),
        .wr_stb_i    (wr_stb_w),
        .rd_en_o     (rd_en_w[0]),
        .rd_data_o   (rd_data_w[0]),
        .irq_o       (irq_w[0]),
        .level_o     (level_w[0])
    );

    a2_io_card #(
        .SLOT(SLOT_1)
    ) u_card_1 (
        .clk_logic_w (clk_logic_w),
        .arst        (arst),
        .rst_i       (sys_rst_w),
        .addr_i      (addr_w),
        .rw_n_i      (rw_n_w),
        .wr_data_i   (wr_data_w),
        .access_stb_i(access_stb_w),
        .end_stb_i   (end_stb_w),
        .wr_stb_i    (wr_stb_w),
        .rd_en_o     (rd_en_w[1]),
        .rd_data_o   (rd_data_w[1]),
        .irq_o       (irq_w[1]),
        .level_o     (level_w[1])
    );

    a2_bus_arbiter u_bus_arbiter (
        .rd_en_i   (rd_en_w),
        .rd_data_i (rd_data_w),
        .irq_i     (irq_w),
        .a2_d_o    (a2_d_o),
        .a2_d_oe_o (a2_d_oe_o),
        .a2_irq_n_o(a2_irq_n_o)
    );

    a2_audio_mix u_audio_mix (
        .clk_logic_w   (clk_logic_w),
        .arst          (arst),
        .rst_i         (sys_rst_w),
        .addr_i        (addr_w),
        .access_stb_i  (access_stb_w),
        .sw_speaker_n_i(sw_speaker_n_i),
        .level_i       (level_w),
        .audio_o       (audio_o)
    );

    // LEDs keep running through an Apple bus reset
    a2_status_leds #(
        .HEARTBEAT_CYCLES(HEARTBEAT_CYCLES),
        .ACT_LED_BIT     (ACT_LED_BIT)
    ) u_status_leds (
        .clk_logic_w(clk_logic_w),
        .arst       (arst),
        .rst_i      (dev_rst_w),
        .end_stb_i  (end_stb_w),
        .led_o      (led_o)
    );

endmodule

// ==== design/a2_io_card.sv ====
/*
 * Slot I/O card
 * 16-byte register file at C0(8+SLOT)x with IRQ and audio level registers
 */

module a2_io_card #(
    parameter int SLOT = 3
) (
    input  logic                  clk_logic_w,
    input  logic                  arst,
    input  logic                  rst_i,
    input  a2_card_pkg::a2_addr_u addr_i,
    input  logic                  rw_n_i,
    input  logic [7:0]            wr_data_i,
    input  logic                  access_stb_i,
    input  logic                  end_stb_i,
    input  logic                  wr_stb_i,
    output logic                  rd_en_o,
    output logic [7:0]            rd_data_o,
    output logic                  irq_o,
    output logic [7:0]            level_o
);

    localparam logic [3:0] DEV_SEL = 4'(a2_card_pkg::DEV_SLOT_BASE + SLOT);

    logic [7:0] reg_file_r [16];
    logic       match_w;
    logic       rd_en_r;
    logic       irq_r;

    // Device select for this slot
    assign match_w = (addr_i.io.page == a2_card_pkg::IO_PAGE) &&
                     (addr_i.io.dev == DEV_SEL);

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            for (int i = 0; i < 16; i++) begin
                reg_file_r[i] <= '0;
            end
        end else if (rst_i) begin
            for (int i = 0; i < 16; i++) begin
                reg_file_r[i] <= '0;
            end
        end else if (wr_stb_i && match_w) begin
            reg_file_r[addr_i.io.reg_sel] <= wr_data_i;
        end
    end

    // Read window spans phi0, through the end strobe
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            rd_en_r <= 1'b0;
            irq_r   <= 1'b0;
        end else if (rst_i) begin
            rd_en_r <= 1'b0;
            irq_r   <= 1'b0;
        end else begin
            if (access_stb_i && match_w && rw_n_i) begin
                rd_en_r <= 1'b1;
            end else if (end_stb_i) begin
                rd_en_r <= 1'b0;
            end
            irq_r <= reg_file_r[a2_card_pkg::REG_IRQ][0];
        end
    end

    assign rd_en_o   = rd_en_r;
    assign rd_data_o = reg_file_r[addr_i.io.reg_sel]; // Address held through phi0
    assign irq_o     = irq_r;
    assign level_o   = reg_file_r[a2_card_pkg::REG_AUDIO];

endmodule

// ==== design/a2_reset_gen.sv ====
/*
 * Power-on reset generator
 * Holds the device reset after arst, then merges in the Apple bus reset
 */

module a2_reset_gen #(
    parameter int RESET_CYCLES = 100
) (
    input  logic clk_logic_w,
    input  logic arst,
    input  logic a2_reset_n_i,
    output logic dev_rst_o,
    output logic sys_rst_o
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    logic [CNT_W-1:0] rst_cnt_r;
    logic             dev_rst_r;
    logic [1:0]       a2_reset_n_sync_r; // Apple reset, two-flop sampled

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            rst_cnt_r <= '0;
            dev_rst_r <= 1'b1;
        end else if (dev_rst_r) begin
            if (rst_cnt_r == CNT_W'(RESET_CYCLES - 1)) begin
                dev_rst_r <= 1'b0;                  // Count done, release
            end else begin
                rst_cnt_r <= rst_cnt_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            a2_reset_n_sync_r <= 2'b00;            // Treat Apple as in reset
        end else begin
            a2_reset_n_sync_r <= {a2_reset_n_sync_r[0], a2_reset_n_i};
        end
    end

    assign dev_rst_o = dev_rst_r;
    assign sys_rst_o = dev_rst_r | ~a2_reset_n_sync_r[1];

endmodule

// ==== design/a2_status_leds.sv ====
/*
 * Status LEDs
 * Heartbeat blinker and phi1 activity indicator
 */

module a2_status_leds #(
    parameter int HEARTBEAT_CYCLES = 10_000_000,
    parameter int ACT_LED_BIT      = 10
) (
    input  logic       clk_logic_w,
    input  logic       arst,
    input  logic       rst_i,
    input  logic       end_stb_i,
    output logic [1:0] led_o
);

    localparam int HB_W = $clog2(HEARTBEAT_CYCLES + 1);

    logic [HB_W-1:0]      hb_cnt_r;
    logic                 hb_led_r;
    logic [ACT_LED_BIT:0] act_cnt_r;   // Counts phi1 rising edges

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            hb_cnt_r  <= '0;
            hb_led_r  <= 1'b0;
            act_cnt_r <= '0;
        end else if (rst_i) begin
            hb_cnt_r  <= '0;
            hb_led_r  <= 1'b0;
            act_cnt_r <= '0;
        end else begin
            if (hb_cnt_r == HB_W'(HEARTBEAT_CYCLES - 1)) begin
                hb_cnt_r <= '0;
                hb_led_r <= ~hb_led_r;
            end else begin
                hb_cnt_r <= hb_cnt_r + 1'b1;
            end
            if (end_stb_i) begin
                act_cnt_r <= act_cnt_r + 1'b1;
            end
        end
    end

    assign led_o = {act_cnt_r[ACT_LED_BIT], hb_led_r};

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the slot-card testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module a2_card_tb -f src.f -o a2_card_sim

out=$(./obj_dir/a2_card_sim)
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
else
    exit 1
fi

// ==== src.f ====
design/a2_card_pkg.sv
design/a2_reset_gen.sv
design/a2_bus_sync.sv
design/a2_io_card.sv
design/a2_bus_arbiter.sv
design/a2_audio_mix.sv
design/a2_status_leds.sv
design/a2_card_top.sv
verif/a2_card_chk.sv
verif/a2_card_tb.sv

// ==== verif/a2_card_chk.sv ====
/*
 * Slot-card checker, bound into the card top level
 * Shadow model of the bus from top-level pins, concurrent assertions
 */

module a2_card_chk #(
    parameter int SLOT_0           = 3,
    parameter int SLOT_1           = 4,
    parameter int HEARTBEAT_CYCLES = 20,
    parameter int ACT_LED_BIT      = 2
) (
    input logic        clk_logic_w,
    input logic        arst,
    input logic        a2_phi1_i,
    input logic [15:0] a2_addr_i,
    input logic        a2_rw_n_i,
    input logic [7:0]  a2_d_i,
    input logic        a2_reset_n_i,
    input logic        sw_speaker_n_i,
    input logic [7:0]  a2_d_o,
    input logic        a2_d_oe_o,
    input logic        a2_irq_n_o,
    input logic [9:0]  audio_o,
    input logic [1:0]  led_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  shadow_r [2][16];
    logic        phi_prev_r;
    logic [7:0]  stable_r;          // Cycles since phi1 last changed
    logic [15:0] lat_addr_r;
    logic        lat_rw_r;
    logic        spk_r;
    logic [31:0] rises_r;
    logic        hb_prev_r;
    logic [7:0]  hb_gap_r;
    logic        hb_seen_r;
    logic [1:0]  card_w;            // 2 = no card selected
    logic        rd_match_w;
    logic [7:0]  rd_byte_w;
    logic [9:0]  audio_exp_w;
    int          fail_cnt = 0;

    always_comb begin
        card_w = 2'd2;
        if (lat_addr_r[15:8] == 8'hC0 && lat_addr_r[7:4] == 4'(8 + SLOT_0)) card_w = 2'd0;
        if (lat_addr_r[15:8] == 8'hC0 && lat_addr_r[7:4] == 4'(8 + SLOT_1)) card_w = 2'd1;
        rd_match_w  = lat_rw_r && (card_w != 2'd2);
        rd_byte_w   = rd_match_w ? shadow_r[card_w[0]][lat_addr_r[3:0]] : 8'h00;
        audio_exp_w = 10'(spk_r ? 8'hFF : 8'h00) + 10'(shadow_r[0][14]) + 10'(shadow_r[1][14]);
    end

    // ======================================================================
    // Shadow model
    // ======================================================================

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            phi_prev_r <= 1'b1;
            stable_r   <= '0;
            lat_addr_r <= '0;
            lat_rw_r   <= 1'b1;
            spk_r      <= 1'b0;
            rises_r    <= '0;
            for (int c = 0; c < 2; c++) begin
                for (int r = 0; r < 16; r++) begin
                    shadow_r[c][r] <= '0;
                end
            end
        end else begin
            phi_prev_r <= a2_phi1_i;
            if (a2_phi1_i != phi_prev_r) begin
                stable_r <= '0;
            end else if (stable_r != 8'hFF) begin
                stable_r <= stable_r + 8'd1;
            end
            if (!phi_prev_r && a2_phi1_i) rises_r <= rises_r + 32'd1;
            if (!a2_reset_n_i) begin
                spk_r <= 1'b0;
                for (int c = 0; c < 2; c++) begin
                    for (int r = 0; r < 16; r++) begin
                        shadow_r[c][r] <= '0;
                    end
                end
            end else if (phi_prev_r && !a2_phi1_i) begin
                lat_addr_r <= a2_addr_i;
                lat_rw_r   <= a2_rw_n_i;
                if (a2_addr_i == 16'hC030 && !sw_speaker_n_i) spk_r <= ~spk_r;
            end else if (!phi_prev_r && a2_phi1_i && !lat_rw_r && card_w != 2'd2) begin
                shadow_r[card_w[0]][lat_addr_r[3:0]] <= a2_d_i;
            end
        end
    end

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            hb_prev_r <= 1'b0;
            hb_gap_r  <= '0;
            hb_seen_r <= 1'b0;
        end else begin
            hb_prev_r <= led_o[0];
            if (led_o[0] != hb_prev_r) begin
                hb_gap_r  <= '0;
                hb_seen_r <= 1'b1;
            end else if (hb_gap_r != 8'hFF) begin
                hb_gap_r <= hb_gap_r + 8'd1;
            end
        end
    end

    // ======================================================================
    // Assertions
    // ======================================================================

    // Phase taken from phi_prev_r, which stable_r counts against

    a_reset: assert property (@(posedge clk_logic_w) disable iff (arst)
        !a2_reset_n_i |-> (!a2_d_oe_o && a2_irq_n_o && audio_o == 10'd0))
        else begin fail_cnt++; $error("outputs active during reset"); end

    a_oe_phi0: assert property (@(posedge clk_logic_w) disable iff (arst || !a2_reset_n_i)
        (!phi_prev_r && stable_r >= 8'd5) |-> (a2_d_oe_o == rd_match_w))
        else begin fail_cnt++; $error("a2_d_oe_o wrong in phi0"); end

    a_oe_phi1: assert property (@(posedge clk_logic_w) disable iff (arst || !a2_reset_n_i)
        (phi_prev_r && stable_r >= 8'd5) |-> !a2_d_oe_o)
        else begin fail_cnt++; $error("a2_d_oe_o high in phi1"); end

    a_rd_data: assert property (@(posedge clk_logic_w) disable iff (arst || !a2_reset_n_i)
        (!phi_prev_r && stable_r >= 8'd5 && rd_match_w) |-> (a2_d_o == rd_byte_w))
        else begin fail_cnt++; $error("read data 0x%0h, model 0x%0h", a2_d_o, rd_byte_w); end

    a_irq: assert property (@(posedge clk_logic_w) disable iff (arst || !a2_reset_n_i)
        (phi_prev_r && stable_r >= 8'd6) |->
        (a2_irq_n_o == !(shadow_r[0][15][0] || shadow_r[1][15][0])))
        else begin fail_cnt++; $error("a2_irq_n_o disagrees with model"); end

    a_audio: assert property (@(posedge clk_logic_w) disable iff (arst || !a2_reset_n_i)
        (stable_r >= 8'd6) |-> (audio_o == audio_exp_w))
        else begin fail_cnt++; $error("audio 0x%0h, model 0x%0h", audio_o, audio_exp_w); end

    a_act_led: assert property (@(posedge clk_logic_w) disable iff (arst)
        (stable_r >= 8'd4) |-> (led_o[1] == rises_r[ACT_LED_BIT]))
        else begin fail_cnt++; $error("activity LED wrong"); end

    a_hb_period: assert property (@(posedge clk_logic_w) disable iff (arst)
        (led_o[0] != hb_prev_r && hb_seen_r) |-> (hb_gap_r == 8'(HEARTBEAT_CYCLES - 1)))
        else begin fail_cnt++; $error("heartbeat period wrong"); end

    a_hb_live: assert property (@(posedge clk_logic_w) disable iff (arst)
        hb_seen_r |-> (hb_gap_r < 8'(HEARTBEAT_CYCLES)))
        else begin fail_cnt++; $error("heartbeat LED stopped"); end

endmodule

bind a2_card_top a2_card_chk #(
    .SLOT_0(3),
    .SLOT_1(4),
    .HEARTBEAT_CYCLES(20),
    .ACT_LED_BIT(2)
) u_chk (.*);

// ==== verif/a2_card_tb.sv ====
/*
 * Slot-card core testbench
 * Bus-cycle stimulus from an LFSR, bound checker does most checking
 */

module a2_card_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PHASE          = 10;     // Clocks per phi1 phase
    localparam int NUM_BUS_CYCLES = 120;
    localparam int LIMIT_NS       = (NUM_BUS_CYCLES * 2 * PHASE + 400) * 4;
    localparam logic [3:0] DEV0   = a2_card_pkg::DEV_SLOT_BASE + 4'd3;
    localparam logic [3:0] DEV1   = a2_card_pkg::DEV_SLOT_BASE + 4'd4;

    logic        clk_logic_w = 1'b0;
    logic        arst;
    logic        a2_phi1_i;
    logic [15:0] a2_addr_i;
    logic        a2_rw_n_i;
    logic [7:0]  a2_d_i;
    logic        a2_reset_n_i;
    logic        sw_speaker_n_i;
    logic [7:0]  a2_d_o;
    logic        a2_d_oe_o;
    logic        a2_irq_n_o;
    logic [9:0]  audio_o;
    logic [1:0]  led_o;

    logic [31:0] lfsr = 32'h620d_793d;
    logic [7:0]  mem [2][16];               // Expected card registers
    logic        spk;
    logic [7:0]  rd_byte;
    logic        oe_seen;
    int          errors = 0;
    int          checks = 0;
    int          rises = 0;

    a2_card_top #(
        .RESET_CYCLES(8),
        .HEARTBEAT_CYCLES(20),
        .ACT_LED_BIT(2)
    ) u_a2_card_top (.*);

    always #2 clk_logic_w = ~clk_logic_w;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] card_addr(input logic card, input logic [3:0] sel);
        return {8'hC0, card ? DEV1 : DEV0, sel};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // One phi1 low then high period, read data sampled late in phi0
    task automatic bus_cycle(input logic [15:0] addr, input logic rw_n, input logic [7:0] data,
                             input logic sw_n);
        oe_seen = 1'b0;
        rd_byte = 8'h00;
        @(posedge clk_logic_w);
        a2_phi1_i      <= 1'b0;
        a2_addr_i      <= addr;
        a2_rw_n_i      <= rw_n;
        a2_d_i         <= data;
        sw_speaker_n_i <= sw_n;
        repeat (PHASE) begin
            @(negedge clk_logic_w);
            if (a2_d_oe_o) begin
                oe_seen = 1'b1;
                rd_byte = a2_d_o;
            end
        end
        @(posedge clk_logic_w);
        a2_phi1_i <= 1'b1;
        repeat (PHASE) @(negedge clk_logic_w);
        rises++;
    endtask

    task automatic write_reg(input logic card, input logic [3:0] sel, input logic [7:0] data);
        bus_cycle(card_addr(card, sel), 1'b0, data, 1'b1);
        mem[card][sel] = data;
        check_val("a2_d_oe_o on write", 32'(oe_seen), 32'd0);
    endtask

    task automatic end_test(input string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        #(LIMIT_NS);
        $display("watchdog: run did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] v;
        logic [9:0]  exp_audio;
        int          n;
        arst = 1'b1;
        a2_phi1_i = 1'b1;
        a2_addr_i = '0;
        a2_rw_n_i = 1'b1;
        a2_d_i = '0;
        a2_reset_n_i = 1'b0;
        sw_speaker_n_i = 1'b1;
        spk = 1'b0;
        for (int c = 0; c < 2; c++) for (int i = 0; i < 16; i++) mem[c][i] = '0;

        // ==================================================================
        // Reset
        // ==================================================================
        repeat (4) @(posedge clk_logic_w);
        arst <= 1'b0;
        repeat (12) begin
            @(negedge clk_logic_w);
            check_val("a2_d_oe_o", 32'(a2_d_oe_o), 32'd0);
            check_val("a2_irq_n_o", 32'(a2_irq_n_o), 32'd1);
            check_val("audio_o", 32'(audio_o), 32'd0);
        end
        @(posedge clk_logic_w);
        a2_reset_n_i <= 1'b1;
        repeat (12) @(posedge clk_logic_w);
        end_test("reset");

        // Random writes, then read back both register files
        for (int i = 0; i < 24; i++) begin
            take_bits(1, r);
            take_bits(4, v);
            take_bits(8, n);
            write_reg(r[0], v[3:0], 8'(n));
        end
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < 16; i++) begin
                bus_cycle(card_addr(c[0], 4'(i)), 1'b1, 8'h00, 1'b1);
                check_val("a2_d_oe_o on read", 32'(oe_seen), 32'd1);
                check_val("a2_d_o", 32'(rd_byte), 32'(mem[c][i]));
            end
        end
        end_test("readback");

        // Other slots and pages leave the bus alone
        for (int i = 0; i < 8; i++) begin
            take_bits(4, v);
            bus_cycle(i[0] ? {8'hC0, 4'hD, v[3:0]} : {8'hC1, DEV0, v[3:0]}, 1'b1, 8'h00, 1'b1);
            check_val("a2_d_oe_o other slot", 32'(oe_seen), 32'd0);
        end
        end_test("ownership");

        for (int i = 0; i < 8; i++) begin
            take_bits(1, r);
            take_bits(1, v);
            write_reg(r[0], a2_card_pkg::REG_IRQ, {7'd0, v[0]});
            check_val("a2_irq_n_o", 32'(a2_irq_n_o),
                      32'(!(mem[0][15][0] || mem[1][15][0])));
        end
        write_reg(1'b0, a2_card_pkg::REG_IRQ, 8'h00);
        write_reg(1'b1, a2_card_pkg::REG_IRQ, 8'h00);
        check_val("a2_irq_n_o", 32'(a2_irq_n_o), 32'd1);
        end_test("interrupts");

        for (int i = 0; i < 8; i++) begin
            take_bits(1, r);
            take_bits(8, v);
            write_reg(r[0], a2_card_pkg::REG_AUDIO, v[7:0]);
            take_bits(1, r);
            bus_cycle(a2_card_pkg::SPEAKER_ADDR, 1'b1, 8'h00, r[0]);
            if (!r[0]) spk = ~spk;
            exp_audio = 10'(spk ? 8'hFF : 8'h00) + 10'(mem[0][14]) + 10'(mem[1][14]);
            check_val("audio_o", 32'(audio_o), 32'(exp_audio));
        end
        end_test("audio");

        // ==================================================================
        // LEDs
        // ==================================================================
        for (int i = 0; i < 8; i++) begin
            bus_cycle(16'hC000, 1'b1, 8'h00, 1'b1);
            check_val("led_o[1]", 32'(led_o[1]), 32'((rises >> 2) & 1));
        end
        n = 0;
        v[0] = led_o[0];
        while (led_o[0] == v[0] && n < 100) begin
            @(negedge clk_logic_w);
            n++;
        end
        v[0] = led_o[0];
        n = 0;
        do begin
            @(negedge clk_logic_w);
            n++;
        end while (led_o[0] == v[0] && n < 100);
        if (n >= 100) begin
            $display("heartbeat LED did not toggle");
            errors++;
        end else begin
            check_val("led_o[0] period", 32'(n), 32'd20);
        end
        end_test("leds");

        errors += u_a2_card_top.u_chk.fail_cnt;
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
